/* hw/fetch_pkg.sv */
package fetch_pkg;

    localparam int ADDR_W = 32;
    localparam int INST_W = 32;

    // LoongArch boot vector
    localparam logic [ADDR_W-1:0] RESET_PC = 32'h1C00_0000;

    // one burst never crosses a 64-byte line, 16 beats when aligned
    localparam int LINE_BYTES = 64;
    localparam int LINE_WORDS = LINE_BYTES / 4;
    localparam int LINE_OFF_W = $clog2(LINE_BYTES);
    localparam int LEN_W      = 8;

    // depth must stay a power of two, pointers wrap on their own
    localparam int QUEUE_DEPTH = 8;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    // burst reader states
    localparam logic [1:0] ST_REQ   = 2'd0;
    localparam logic [1:0] ST_RECV  = 2'd1;
    localparam logic [1:0] ST_DRAIN = 2'd2;

    // major opcodes, bits 31:26
    localparam logic [5:0] OP_B         = 6'b010100;
    localparam logic [5:0] OP_BL        = 6'b010101;
    // beq, bne, blt, bge, bltu, bgeu
    localparam logic [5:0] OP_BEQ_FIRST = 6'b010110;
    localparam logic [5:0] OP_BGEU_LAST = 6'b011011;

    // b / bl format, offs[15:0] sits above offs[25:16]
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } inst_i26_t;

    // conditional branch format
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_2ri16_t;

    typedef union packed {
        inst_i26_t   i26;
        inst_2ri16_t ri16;
    } inst_word_u;

endpackage

/* hw/fetch_burst_reader.sv */
`timescale 1ns/1ps

module fetch_burst_reader (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic                         i_redirect,
    input  logic [fetch_pkg::ADDR_W-1:0] i_redirect_pc,
    input  logic                         i_dec_redirect,
    input  logic [fetch_pkg::ADDR_W-1:0] i_dec_target,
    input  logic                         i_full,
    input  logic                         i_arready,
    input  logic [fetch_pkg::INST_W-1:0] i_rdata,
    input  logic                         i_rlast,
    input  logic                         i_rvalid,
    output logic [fetch_pkg::ADDR_W-1:0] o_araddr,
    output logic [fetch_pkg::LEN_W-1:0]  o_arlen,
    output logic                         o_arvalid,
    output logic                         o_rready,
    output logic                         o_push,
    output logic [fetch_pkg::ADDR_W-1:0] o_push_pc,
    output logic [fetch_pkg::INST_W-1:0] o_push_inst,
    output logic                         o_flush
);
    import fetch_pkg::*;

    logic [1:0]        state;
    logic [ADDR_W-1:0] pc;
    logic              redirect_any;
    logic [ADDR_W-1:0] redirect_target;
    logic              beat;
    logic              launch;
    logic [LEN_W-1:0]  burst_len;

    // external redirect wins over the decoder
    assign redirect_any    = i_redirect | i_dec_redirect;
    assign redirect_target = i_redirect ? i_redirect_pc : i_dec_target;

    // stale beats are always taken, live ones only with queue room
    assign o_rready = (state == ST_RECV && !i_full) || state == ST_DRAIN;
    assign beat     = i_rvalid && o_rready;

    // no launch in a redirect cycle since pc is about to move
    assign launch = state == ST_REQ && !o_arvalid && !redirect_any;

    // words left up to the line boundary minus one
    assign burst_len = LEN_W'(LINE_WORDS - 1) - LEN_W'(pc[LINE_OFF_W-1:2]);

    assign o_flush     = redirect_any;
    assign o_push      = beat && state == ST_RECV && !redirect_any;
    assign o_push_pc   = pc;
    assign o_push_inst = i_rdata;

    // pc always names the next beat to arrive
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pc <= RESET_PC;
        end else if (redirect_any) begin
            pc <= redirect_target;
        end else if (o_push) begin
            pc <= pc + ADDR_W'(4);
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state     <= ST_REQ;
            o_arvalid <= 1'b0;
        end else begin
            case (state)
                ST_REQ: begin
                    if (launch) begin
                        o_arvalid <= 1'b1;
                    end else if (o_arvalid) begin
                        if (i_arready) begin
                            o_arvalid <= 1'b0;
                        end
                        // address already on the bus so its data is now stale
                        if (redirect_any) begin
                            state <= ST_DRAIN;
                        end else if (i_arready) begin
                            state <= ST_RECV;
                        end
                    end
                end
                ST_RECV: begin
                    if (beat && i_rlast) begin
                        state <= ST_REQ;
                    end else if (redirect_any) begin
                        state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    if (o_arvalid && i_arready) begin
                        o_arvalid <= 1'b0;
                    end
                    if (beat && i_rlast) begin
                        state <= ST_REQ;
                    end
                end
                default: begin
                    state <= ST_REQ;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (launch) begin
            o_araddr <= pc;
            o_arlen  <= burst_len;
        end
    end

    ar_stable: assert property (
        @(posedge aclk) disable iff (!aresetn)
        o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr) && $stable(o_arlen)
    ) else $error("read request changed before arready");

endmodule

/* hw/inst_queue.sv */
`timescale 1ns/1ps

module inst_queue (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic                         i_push,
    input  logic [fetch_pkg::ADDR_W-1:0] i_push_pc,
    input  logic [fetch_pkg::INST_W-1:0] i_push_inst,
    input  logic                         i_pop,
    input  logic                         i_flush,
    output logic                         o_full,
    output logic                         o_valid,
    output logic [fetch_pkg::ADDR_W-1:0] o_pc,
    output logic [fetch_pkg::INST_W-1:0] o_inst
);
    import fetch_pkg::*;

    logic [ADDR_W-1:0]      pc_mem   [QUEUE_DEPTH];
    logic [INST_W-1:0]      inst_mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] head;
    logic [QUEUE_PTR_W-1:0] tail;
    logic [QUEUE_CNT_W-1:0] count;
    logic                   do_push;
    logic                   do_pop;

    assign o_full  = count == QUEUE_CNT_W'(QUEUE_DEPTH);
    assign o_valid = count != '0;
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && o_valid;

    // head entry shown directly
    assign o_pc   = pc_mem[head];
    assign o_inst = inst_mem[head];

    always_ff @(posedge aclk) begin
        if (!aresetn || i_flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                tail <= tail + 1'b1;
            end
            if (do_pop) begin
                head <= head + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (do_push) begin
            pc_mem[tail]   <= i_push_pc;
            inst_mem[tail] <= i_push_inst;
        end
    end

    no_overflow: assert property (
        @(posedge aclk) disable iff (!aresetn)
        i_push |-> !o_full
    ) else $error("push while queue full");

    no_underflow: assert property (
        @(posedge aclk) disable iff (!aresetn)
        i_pop |-> o_valid
    ) else $error("pop while queue empty");

endmodule

/* hw/branch_predecoder.sv */
`timescale 1ns/1ps

module branch_predecoder (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic                         i_valid,
    input  logic [fetch_pkg::ADDR_W-1:0] i_pc,
    input  fetch_pkg::inst_word_u        i_inst,
    input  logic                         i_flush,
    input  logic                         i_inst_ready,
    output logic                         o_pop,
    output logic                         o_inst_valid,
    output logic [fetch_pkg::ADDR_W-1:0] o_inst_pc,
    output logic [fetch_pkg::INST_W-1:0] o_inst,
    output logic                         o_pred_taken,
    output logic                         o_dec_redirect,
    output logic [fetch_pkg::ADDR_W-1:0] o_dec_target
);
    import fetch_pkg::*;

    logic              is_uncond;
    logic              is_cond;
    logic              taken;
    logic [ADDR_W-1:0] offs;
    logic [ADDR_W-1:0] target;

    // b / bl through the I26 view, conditionals through 2RI16
    always_comb begin
        is_uncond = i_inst.i26.opcode == OP_B || i_inst.i26.opcode == OP_BL;
        is_cond   = i_inst.ri16.opcode >= OP_BEQ_FIRST
                    && i_inst.ri16.opcode <= OP_BGEU_LAST;
        if (is_uncond) begin
            offs = {{(ADDR_W - 28){i_inst.i26.offs_hi[9]}},
                    i_inst.i26.offs_hi, i_inst.i26.offs_lo, 2'b00};
        end else begin
            offs = {{(ADDR_W - 18){i_inst.ri16.offs16[15]}},
                    i_inst.ri16.offs16, 2'b00};
        end
        // static rule, backward conditionals are loops
        taken  = is_uncond || (is_cond && i_inst.ri16.offs16[15]);
        target = i_pc + offs;
    end

    // nothing enters during a flush, the queue head is stale
    assign o_pop = i_valid && (!o_inst_valid || i_inst_ready) && !i_flush;

    // redirect fires as the branch leaves, so the flush never drops it
    assign o_dec_redirect = o_inst_valid && o_pred_taken && i_inst_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_inst_valid <= 1'b0;
        end else if (i_flush) begin
            o_inst_valid <= 1'b0;
        end else if (o_pop) begin
            o_inst_valid <= 1'b1;
        end else if (i_inst_ready) begin
            o_inst_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (o_pop) begin
            o_inst_pc    <= i_pc;
            o_inst       <= i_inst;
            o_pred_taken <= taken;
            o_dec_target <= target;
        end
    end

    out_hold: assert property (
        @(posedge aclk) disable iff (!aresetn)
        o_inst_valid && !i_inst_ready && !i_flush |=>
            o_inst_valid && $stable(o_inst_pc) && $stable(o_inst)
            && $stable(o_pred_taken)
    ) else $error("output changed under back-pressure");

endmodule

/* hw/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic                         i_redirect,
    input  logic [fetch_pkg::ADDR_W-1:0] i_redirect_pc,
    output logic [fetch_pkg::ADDR_W-1:0] o_araddr,
    output logic [fetch_pkg::LEN_W-1:0]  o_arlen,
    output logic                         o_arvalid,
    input  logic                         i_arready,
    input  logic [fetch_pkg::INST_W-1:0] i_rdata,
    input  logic                         i_rlast,
    input  logic                         i_rvalid,
    output logic                         o_rready,
    input  logic                         i_inst_ready,
    output logic                         o_inst_valid,
    output logic [fetch_pkg::ADDR_W-1:0] o_inst_pc,
    output logic [fetch_pkg::INST_W-1:0] o_inst,
    output logic                         o_pred_taken
);
    import fetch_pkg::*;

    logic              push;
    logic [ADDR_W-1:0] push_pc;
    logic [INST_W-1:0] push_inst;
    logic              full;
    logic              q_valid;
    logic [ADDR_W-1:0] q_pc;
    logic [INST_W-1:0] q_inst;
    logic              pop;
    logic              flush;
    logic              dec_redirect;
    logic [ADDR_W-1:0] dec_target;

    fetch_burst_reader u_reader (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_redirect     (i_redirect),
        .i_redirect_pc  (i_redirect_pc),
        .i_dec_redirect (dec_redirect),
        .i_dec_target   (dec_target),
        .i_full         (full),
        .i_arready      (i_arready),
        .i_rdata        (i_rdata),
        .i_rlast        (i_rlast),
        .i_rvalid       (i_rvalid),
        .o_araddr       (o_araddr),
        .o_arlen        (o_arlen),
        .o_arvalid      (o_arvalid),
        .o_rready       (o_rready),
        .o_push         (push),
        .o_push_pc      (push_pc),
        .o_push_inst    (push_inst),
        .o_flush        (flush)
    );

    inst_queue u_queue (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_push      (push),
        .i_push_pc   (push_pc),
        .i_push_inst (push_inst),
        .i_pop       (pop),
        .i_flush     (flush),
        .o_full      (full),
        .o_valid     (q_valid),
        .o_pc        (q_pc),
        .o_inst      (q_inst)
    );

    branch_predecoder u_predecoder (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_valid        (q_valid),
        .i_pc           (q_pc),
        .i_inst         (q_inst),
        .i_flush        (flush),
        .i_inst_ready   (i_inst_ready),
        .o_pop          (pop),
        .o_inst_valid   (o_inst_valid),
        .o_inst_pc      (o_inst_pc),
        .o_inst         (o_inst),
        .o_pred_taken   (o_pred_taken),
        .o_dec_redirect (dec_redirect),
        .o_dec_target   (dec_target)
    );

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic o_aclk,
    output logic o_aresetn
);

    initial begin
        o_aclk = 1'b0;
        forever #(PERIOD_NS / 2) o_aclk = ~o_aclk;
    end

    // release lines up with the 1 ns input skew
    initial begin
        o_aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_aclk);
        #1 o_aresetn = 1'b1;
    end

endmodule

/* tests/tb_axi_mem.sv */
`timescale 1ns/1ps

// AXI read slave serving one burst at a time with random gaps on arready and rvalid
module tb_axi_mem #(
    parameter int SEED = 69412
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic [31:0] i_araddr,
    input  logic [7:0]  i_arlen,
    input  logic        i_arvalid,
    output logic        o_arready,
    output logic        o_rvalid,
    output logic        o_rlast,
    input  logic        i_rready,
    output logic [31:0] o_beat_addr
);
    integer      seed;
    logic        in_reset;
    logic        busy;
    logic        ar_hs;
    logic        r_hs;
    logic [31:0] ar_addr;
    logic [7:0]  ar_len;
    logic [7:0]  beats_left;

    initial begin
        seed        = SEED;
        in_reset    = 1'b1;
        busy        = 1'b0;
        beats_left  = '0;
        o_arready   = 1'b0;
        o_rvalid    = 1'b0;
        o_rlast     = 1'b0;
        o_beat_addr = '0;
        forever begin
            @(posedge aclk);
            in_reset = !aresetn;
            ar_hs    = i_arvalid && o_arready;
            r_hs     = o_rvalid && i_rready;
            ar_addr  = i_araddr;
            ar_len   = i_arlen;
            #1;
            if (in_reset) begin
                busy = 1'b0;
            end else if (ar_hs) begin
                busy        = 1'b1;
                o_beat_addr = ar_addr;
                beats_left  = ar_len;
            end else if (r_hs) begin
                busy        = !o_rlast;
                o_beat_addr = o_beat_addr + 32'd4;
                beats_left  = beats_left - 8'd1;
            end
            // a beat already offered stays until taken
            if (!o_rvalid || r_hs || !busy) begin
                o_rvalid = busy && (($random(seed) & 3) != 0);
            end
            o_rlast   = busy && beats_left == 8'd0;
            o_arready = !in_reset && !busy && (($random(seed) & 1) != 0);
        end
    end

endmodule

/* tests/tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top;
    localparam logic [31:0] BOOT_PC   = 32'h1C00_0000;
    localparam logic [31:0] B_PC      = 32'h1C00_0100;
    localparam logic [31:0] B_TARGET  = 32'h1C00_0400;
    localparam logic [31:0] BL_PC     = 32'h1C00_0440;
    localparam logic [31:0] BL_TARGET = 32'h1C00_0800;
    localparam logic [31:0] BNE_PC    = 32'h1C00_0808;
    localparam logic [31:0] BEQ_PC    = 32'h1C00_0850;
    localparam logic [31:0] LOOP_PC   = 32'h1C00_0810;
    localparam logic [31:0] JUMP_PC   = 32'h1C00_2000;
    // 5 tests of about 200 instructions at up to 3 cycles each, plus margin
    localparam int CYCLE_LIMIT = 5 * 200 * 3 + 1000;

    logic        aclk;
    logic        aresetn;
    logic        i_redirect;
    logic [31:0] i_redirect_pc;
    logic [31:0] o_araddr;
    logic [7:0]  o_arlen;
    logic        o_arvalid;
    logic        i_arready;
    logic [31:0] i_rdata;
    logic        i_rlast;
    logic        i_rvalid;
    logic        o_rready;
    logic        i_inst_ready;
    logic        o_inst_valid;
    logic [31:0] o_inst_pc;
    logic [31:0] o_inst;
    logic        o_pred_taken;
    logic [31:0] beat_addr;
    integer      seed;
    logic        stall;
    logic        saw_rready_low = 1'b0;
    logic [31:0] expect_pc = BOOT_PC;
    logic [31:0] last_pc = '0;
    int          cycle_count = 0;
    int          checks = 0;
    int          errors = 0;
    int          accepted = 0;
    int          taken_count = 0;
    int          t_err;
    int          t_acc;
    int          t_taken;
    event        accepted_ev;

    // non-branch op tagged with its address unless a branch is planted there
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        case (addr)
            B_PC:    mem_word = {6'b010100, 16'h00C0, 10'h000};
            BL_PC:   mem_word = {6'b010101, 16'h00F0, 10'h000};
            BNE_PC:  mem_word = {6'b010111, 16'h0008, 5'd4, 5'd5};
            BEQ_PC:  mem_word = {6'b010110, 16'hFFF0, 5'd4, 5'd5};
            default: mem_word = {6'b000000, addr[27:2] ^ {addr[31:28], addr[1:0], 20'h0}};
        endcase
    endfunction

    function automatic logic ref_taken(input logic [31:0] word);
        if (word[31:26] == 6'b010100 || word[31:26] == 6'b010101) begin
            ref_taken = 1'b1;
        end else begin
            // conditionals only when jumping backward
            ref_taken = word[31:26] >= 6'b010110 && word[31:26] <= 6'b011011 && word[25];
        end
    endfunction

    function automatic logic [31:0] ref_next(input logic [31:0] pc);
        logic [31:0] word;
        word = mem_word(pc);
        if (!ref_taken(word)) begin
            ref_next = pc + 32'd4;
        end else if (word[31:27] == 5'b01010) begin
            ref_next = pc + {{4{word[9]}}, word[9:0], word[25:10], 2'b00};
        end else begin
            ref_next = pc + {{14{word[25]}}, word[25:10], 2'b00};
        end
    endfunction

    tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(4)) clk_gen (
        .o_aclk    (aclk),
        .o_aresetn (aresetn)
    );

    tb_axi_mem #(.SEED(69412)) mem (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_araddr    (o_araddr),
        .i_arlen     (o_arlen),
        .i_arvalid   (o_arvalid),
        .o_arready   (i_arready),
        .o_rvalid    (i_rvalid),
        .o_rlast     (i_rlast),
        .i_rready    (o_rready),
        .o_beat_addr (beat_addr)
    );

    assign i_rdata = mem_word(beat_addr);

    fetch_top DUT (.*);

    initial begin
        seed          = 69412;
        stall         = 1'b0;
        i_inst_ready  = 1'b0;
        i_redirect    = 1'b0;
        i_redirect_pc = '0;
        forever begin
            @(posedge aclk);
            #1 i_inst_ready = !stall && (($random(seed) & 3) != 0);
        end
    end

    // everything sampled half a cycle before the edge that takes it
    always @(negedge aclk) begin
        if (aresetn && o_arvalid && i_arready) begin
            checks++;
            assert (o_arlen == 8'((64 - o_araddr[5:0]) / 4 - 1)) else begin
                $display("FAILED t=%0t o_arlen expected %0d got %0d",
                         $time, 8'((64 - o_araddr[5:0]) / 4 - 1), o_arlen);
                errors++;
            end
        end
        if (aresetn && i_rvalid && !o_rready) begin
            saw_rready_low = 1'b1;
        end
        if (aresetn && o_inst_valid && i_inst_ready) begin
            checks += 3;
            assert (o_inst_pc == expect_pc) else begin
                $display("FAILED t=%0t o_inst_pc expected %h got %h",
                         $time, expect_pc, o_inst_pc);
                errors++;
            end
            assert (o_inst == mem_word(expect_pc)) else begin
                $display("FAILED t=%0t o_inst expected %h got %h",
                         $time, mem_word(expect_pc), o_inst);
                errors++;
            end
            assert (o_pred_taken == ref_taken(mem_word(expect_pc))) else begin
                $display("FAILED t=%0t o_pred_taken expected %b got %b",
                         $time, ref_taken(mem_word(expect_pc)), o_pred_taken);
                errors++;
            end
            if (o_pred_taken) begin
                taken_count++;
            end
            last_pc   = o_inst_pc;
            expect_pc = ref_next(expect_pc);
            accepted++;
            -> accepted_ev;
        end
        if (i_redirect) begin
            expect_pc = i_redirect_pc;
        end
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge aclk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the fetch stream stopped", cycle_count);
        $display("Test failed");
        $finish;
    end

    task automatic wait_for_pc(input logic [31:0] pc);
        do begin
            @(accepted_ev);
        end while (last_pc != pc);
    endtask

    task automatic start_test();
        t_err   = errors;
        t_acc   = accepted;
        t_taken = taken_count;
    endtask

    task automatic end_test(input string name);
        if (errors == t_err) begin
            $display("%s: ok, %0d instructions", name, accepted - t_acc);
        end else begin
            $display("%s: %0d errors", name, errors - t_err);
        end
    endtask

    initial begin
        @(posedge aresetn);
        start_test();
        wait_for_pc(BOOT_PC + 32'h0C0);
        end_test("test 1, sequential fetch from reset");

        start_test();
        wait_for_pc(B_TARGET);
        wait_for_pc(BL_TARGET);
        assert (taken_count - t_taken == 2) else begin
            $display("B or BL did not show up as a taken branch");
            errors++;
        end
        end_test("test 2, b and bl");

        start_test();
        wait_for_pc(BEQ_PC);
        wait_for_pc(LOOP_PC);
        end_test("test 3, backward beq and forward bne");

        // redirect while beats of a burst are still on the way
        start_test();
        do begin
            @(negedge aclk);
        end while (!(i_rvalid && o_rready && !i_rlast));
        @(posedge aclk);
        #1;
        i_redirect    = 1'b1;
        i_redirect_pc = JUMP_PC;
        @(posedge aclk);
        #1 i_redirect = 1'b0;
        wait_for_pc(JUMP_PC);
        end_test("test 4, redirect in the middle of a burst");

        start_test();
        saw_rready_low = 1'b0;
        for (int r = 1; r <= 3; r++) begin
            @(negedge aclk);
            stall = 1'b1;
            repeat (60) @(negedge aclk);
            stall = 1'b0;
            wait_for_pc(JUMP_PC + 32'(r * 128));
        end
        assert (saw_rready_low) else begin
            $display("rready never dropped while the queue was full");
            errors++;
        end
        end_test("test 5, long output stalls");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* project.f */
hw/fetch_pkg.sv
hw/fetch_burst_reader.sv
hw/inst_queue.sv
hw/branch_predecoder.sv
hw/fetch_top.sv
tests/tb_clock.sv
tests/tb_axi_mem.sv
tests/tb_fetch_top.sv
